// ==== logic/dlxIsaPkg.sv ====
package dlxIsaPkg;

	// instruction field positions
	localparam int OPC_HI = 31;
	localparam int OPC_LO = 26;
	localparam int RS1_HI = 25;
	localparam int RS1_LO = 21;
	localparam int RS2_HI = 20;
	localparam int RS2_LO = 16;
	localparam int RD_HI = 15;
	localparam int RD_LO = 11;
	localparam int IMM_HI = 15;
	localparam int IMM_LO = 0;
	localparam int FUNC_HI = 5;
	localparam int FUNC_LO = 0;
	localparam int TARGET_HI = 25;
	localparam int TARGET_LO = 0;

	localparam logic [31:0] NOP_WORD = 32'h0000_0015;	// SPECIAL with func 0x15
	localparam logic [4:0] LINK_REG = 5'd31;

	typedef enum logic [5:0]
	{
		OP_SPECIAL = 6'h00,
		OP_J = 6'h02, OP_JAL = 6'h03,
		OP_BEQZ = 6'h04, OP_BNEZ = 6'h05,
		OP_ADDI = 6'h08, OP_ADDUI = 6'h09, OP_SUBI = 6'h0a, OP_SUBUI = 6'h0b,
		OP_ANDI = 6'h0c, OP_ORI = 6'h0d, OP_XORI = 6'h0e, OP_LHI = 6'h0f,
		OP_JR = 6'h12, OP_JALR = 6'h13,
		OP_SLLI = 6'h14, OP_SRLI = 6'h16, OP_SRAI = 6'h17,
		OP_SEQI = 6'h18, OP_SNEI = 6'h19, OP_SLTI = 6'h1a,
		OP_SGTI = 6'h1b, OP_SLEI = 6'h1c, OP_SGEI = 6'h1d,
		OP_LB = 6'h20, OP_LH = 6'h21, OP_LW = 6'h23,
		OP_LBU = 6'h24, OP_LHU = 6'h25,
		OP_SB = 6'h28, OP_SH = 6'h29, OP_SW = 6'h2b
	} opcodeT;

	// R-type function field
	typedef enum logic [5:0]
	{
		FN_SLL = 6'h04, FN_SRL = 6'h06, FN_SRA = 6'h07,
		FN_ADD = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23,
		FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26,
		FN_SEQ = 6'h28, FN_SNE = 6'h29, FN_SLT = 6'h2a,
		FN_SGT = 6'h2b, FN_SLE = 6'h2c, FN_SGE = 6'h2d
	} funcT;

endpackage

// ==== logic/dlxCtrlPkg.sv ====
package dlxCtrlPkg;

	typedef enum logic [4:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SEQ,
		ALU_SNE,
		ALU_SLT,
		ALU_SGT,
		ALU_SLE,
		ALU_SGE,
		ALU_PASSB	// second operand straight through
	} aluOpT;

	// where EX takes an operand from
	typedef enum logic [1:0]
	{
		FWD_REGFILE = 2'd0,
		FWD_FROM_EXMEM = 2'd1,
		FWD_FROM_MEMWB = 2'd2
	} fwdSelT;

	typedef enum logic [1:0]
	{
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} memSizeT;

endpackage

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
(
	input  logic [31:0]         instr,
	output logic [4:0]          rS1,
	output logic [4:0]          rS2,
	output logic [4:0]          dest,
	output logic [31:0]         imm32,
	output logic [25:0]         jumpTarget,
	output dlxCtrlPkg::aluOpT   aluOp,
	output dlxCtrlPkg::memSizeT memSize,
	output logic                aluSrcImm,
	output logic                usesRs1,
	output logic                usesRs2,
	output logic                regWr,
	output logic                memRd,
	output logic                memWr,
	output logic                memSigned,
	output logic                loadHigh,
	output logic                link,
	output logic                branchEqz,
	output logic                branchNez,
	output logic                jump,
	output logic                jumpReg,
	output logic                illegal
);

	dlxIsaPkg::opcodeT opcode;
	dlxIsaPkg::funcT   func;
	logic [4:0]        rD;
	logic [15:0]       imm16;
	logic              zeroExt;
	logic              immAlu;	// reg-imm ALU form
	logic              isLoad;
	logic              isStore;

	assign opcode = dlxIsaPkg::opcodeT'(instr[dlxIsaPkg::OPC_HI:dlxIsaPkg::OPC_LO]);
	assign func = dlxIsaPkg::funcT'(instr[dlxIsaPkg::FUNC_HI:dlxIsaPkg::FUNC_LO]);
	assign rS1 = instr[dlxIsaPkg::RS1_HI:dlxIsaPkg::RS1_LO];
	assign rS2 = instr[dlxIsaPkg::RS2_HI:dlxIsaPkg::RS2_LO];
	assign rD = instr[dlxIsaPkg::RD_HI:dlxIsaPkg::RD_LO];
	assign imm16 = instr[dlxIsaPkg::IMM_HI:dlxIsaPkg::IMM_LO];
	assign jumpTarget = instr[dlxIsaPkg::TARGET_HI:dlxIsaPkg::TARGET_LO];
	assign imm32 = zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

	always_comb
	begin
		dest = 5'd0;
		aluOp = dlxCtrlPkg::ALU_PASSB;
		memSize = dlxCtrlPkg::MEM_WORD;
		aluSrcImm = 1'b0;
		usesRs1 = 1'b0;
		usesRs2 = 1'b0;
		regWr = 1'b0;
		memRd = 1'b0;
		memWr = 1'b0;
		memSigned = 1'b0;
		loadHigh = 1'b0;
		link = 1'b0;
		branchEqz = 1'b0;
		branchNez = 1'b0;
		jump = 1'b0;
		jumpReg = 1'b0;
		illegal = 1'b0;
		zeroExt = 1'b0;
		immAlu = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;

		case (opcode)
			dlxIsaPkg::OP_SPECIAL:
			begin
				if (instr != dlxIsaPkg::NOP_WORD)	// nop falls through with no writes
				begin
					usesRs1 = 1'b1;
					usesRs2 = 1'b1;
					regWr = 1'b1;
					dest = rD;
					case (func)
						dlxIsaPkg::FN_ADD, dlxIsaPkg::FN_ADDU: aluOp = dlxCtrlPkg::ALU_ADD;
						dlxIsaPkg::FN_SUB, dlxIsaPkg::FN_SUBU: aluOp = dlxCtrlPkg::ALU_SUB;
						dlxIsaPkg::FN_AND: aluOp = dlxCtrlPkg::ALU_AND;
						dlxIsaPkg::FN_OR: aluOp = dlxCtrlPkg::ALU_OR;
						dlxIsaPkg::FN_XOR: aluOp = dlxCtrlPkg::ALU_XOR;
						dlxIsaPkg::FN_SLL: aluOp = dlxCtrlPkg::ALU_SLL;
						dlxIsaPkg::FN_SRL: aluOp = dlxCtrlPkg::ALU_SRL;
						dlxIsaPkg::FN_SRA: aluOp = dlxCtrlPkg::ALU_SRA;
						dlxIsaPkg::FN_SEQ: aluOp = dlxCtrlPkg::ALU_SEQ;
						dlxIsaPkg::FN_SNE: aluOp = dlxCtrlPkg::ALU_SNE;
						dlxIsaPkg::FN_SLT: aluOp = dlxCtrlPkg::ALU_SLT;
						dlxIsaPkg::FN_SGT: aluOp = dlxCtrlPkg::ALU_SGT;
						dlxIsaPkg::FN_SLE: aluOp = dlxCtrlPkg::ALU_SLE;
						dlxIsaPkg::FN_SGE: aluOp = dlxCtrlPkg::ALU_SGE;
						default:
						begin
							usesRs1 = 1'b0;
							usesRs2 = 1'b0;
							regWr = 1'b0;
							dest = 5'd0;
							illegal = 1'b1;
						end
					endcase
				end
			end
			dlxIsaPkg::OP_ADDI, dlxIsaPkg::OP_ADDUI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_ADD;
			end
			dlxIsaPkg::OP_SUBI, dlxIsaPkg::OP_SUBUI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_SUB;
			end
			dlxIsaPkg::OP_ANDI:
			begin
				immAlu = 1'b1;
				zeroExt = 1'b1;
				aluOp = dlxCtrlPkg::ALU_AND;
			end
			dlxIsaPkg::OP_ORI:
			begin
				immAlu = 1'b1;
				zeroExt = 1'b1;
				aluOp = dlxCtrlPkg::ALU_OR;
			end
			dlxIsaPkg::OP_XORI:
			begin
				immAlu = 1'b1;
				zeroExt = 1'b1;
				aluOp = dlxCtrlPkg::ALU_XOR;
			end
			dlxIsaPkg::OP_SLLI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_SLL;
			end
			dlxIsaPkg::OP_SRLI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_SRL;
			end
			dlxIsaPkg::OP_SRAI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_SRA;
			end
			dlxIsaPkg::OP_SEQI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_SEQ;
			end
			dlxIsaPkg::OP_SNEI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_SNE;
			end
			dlxIsaPkg::OP_SLTI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_SLT;
			end
			dlxIsaPkg::OP_SGTI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_SGT;
			end
			dlxIsaPkg::OP_SLEI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_SLE;
			end
			dlxIsaPkg::OP_SGEI:
			begin
				immAlu = 1'b1;
				aluOp = dlxCtrlPkg::ALU_SGE;
			end
			dlxIsaPkg::OP_LHI:
			begin
				regWr = 1'b1;
				dest = rS2;
				aluSrcImm = 1'b1;
				loadHigh = 1'b1;	// EX shifts imm into upper half
			end
			dlxIsaPkg::OP_LB, dlxIsaPkg::OP_LH, dlxIsaPkg::OP_LW:
			begin
				isLoad = 1'b1;
				memSigned = 1'b1;
			end
			dlxIsaPkg::OP_LBU, dlxIsaPkg::OP_LHU:
			begin
				isLoad = 1'b1;
				zeroExt = 1'b1;
			end
			dlxIsaPkg::OP_SB, dlxIsaPkg::OP_SH, dlxIsaPkg::OP_SW:
			begin
				isStore = 1'b1;
			end
			dlxIsaPkg::OP_BEQZ:
			begin
				usesRs1 = 1'b1;
				branchEqz = 1'b1;
			end
			dlxIsaPkg::OP_BNEZ:
			begin
				usesRs1 = 1'b1;
				branchNez = 1'b1;
			end
			dlxIsaPkg::OP_J:
			begin
				jump = 1'b1;
			end
			dlxIsaPkg::OP_JAL:
			begin
				jump = 1'b1;
				link = 1'b1;
				regWr = 1'b1;
				dest = dlxIsaPkg::LINK_REG;
			end
			dlxIsaPkg::OP_JR:
			begin
				usesRs1 = 1'b1;
				jump = 1'b1;
				jumpReg = 1'b1;
			end
			dlxIsaPkg::OP_JALR:
			begin
				usesRs1 = 1'b1;
				jump = 1'b1;
				jumpReg = 1'b1;
				link = 1'b1;
				regWr = 1'b1;
				dest = dlxIsaPkg::LINK_REG;
			end
			default: illegal = 1'b1;
		endcase

		if (immAlu || isLoad)	// both write rS2
		begin
			aluSrcImm = 1'b1;
			usesRs1 = 1'b1;
			regWr = 1'b1;
			dest = rS2;
		end
		if (isLoad || isStore)
		begin
			aluSrcImm = 1'b1;
			usesRs1 = 1'b1;
			aluOp = dlxCtrlPkg::ALU_ADD;	// base plus offset
			case (opcode)
				dlxIsaPkg::OP_LB, dlxIsaPkg::OP_LBU, dlxIsaPkg::OP_SB: memSize = dlxCtrlPkg::MEM_BYTE;
				dlxIsaPkg::OP_LH, dlxIsaPkg::OP_LHU, dlxIsaPkg::OP_SH: memSize = dlxCtrlPkg::MEM_HALF;
				default: memSize = dlxCtrlPkg::MEM_WORD;
			endcase
		end
		memRd = isLoad;
		if (isStore)
		begin
			usesRs2 = 1'b1;	// store data
			memWr = 1'b1;
		end
	end

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit
(
	input  logic               clk,
	input  logic               rst,
	input  logic               instrValid,
	input  logic [4:0]         rS1,
	input  logic [4:0]         rS2,
	input  logic [4:0]         dest,
	input  logic               usesRs1,
	input  logic               usesRs2,
	input  logic               regWr,
	input  logic               memRd,
	output dlxCtrlPkg::fwdSelT fwdA,
	output dlxCtrlPkg::fwdSelT fwdB,
	output logic               stall
);

	logic [4:0] dest1;	// previous issued instruction
	logic [4:0] dest2;	// the one before that
	logic       wr1;
	logic       wr2;
	logic       load1;
	logic       issue;

	function automatic logic srcHit(input logic [4:0] src, input logic used,
		input logic [4:0] histDest, input logic histWr);
		srcHit = used && histWr && (src != 5'd0) && (src == histDest);
	endfunction

	function automatic dlxCtrlPkg::fwdSelT pickFwd(input logic hitNear, input logic hitFar);
		if (hitNear)
			pickFwd = dlxCtrlPkg::FWD_FROM_EXMEM;
		else if (hitFar)
			pickFwd = dlxCtrlPkg::FWD_FROM_MEMWB;
		else
			pickFwd = dlxCtrlPkg::FWD_REGFILE;
	endfunction

	assign fwdA = pickFwd(srcHit(rS1, usesRs1, dest1, wr1), srcHit(rS1, usesRs1, dest2, wr2));
	assign fwdB = pickFwd(srcHit(rS2, usesRs2, dest1, wr1), srcHit(rS2, usesRs2, dest2, wr2));

	// load result not ready for the very next instruction
	assign stall = instrValid && load1 &&
		(srcHit(rS1, usesRs1, dest1, wr1) || srcHit(rS2, usesRs2, dest1, wr1));

	assign issue = instrValid && !stall;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr1 <= 1'b0;
			wr2 <= 1'b0;
			load1 <= 1'b0;
		end
		else
		begin
			wr1 <= issue && regWr;	// bubble has no write
			load1 <= issue && memRd;
			wr2 <= wr1;
		end
	end

	always_ff @(posedge clk)
	begin
		dest1 <= dest;
		dest2 <= dest1;
	end

endmodule

// ==== logic/idExRegister.sv ====
`timescale 1ns/1ps

module idExRegister
(
	input  logic                clk,
	input  logic                rst,
	input  logic                instrValid,
	input  logic                stall,
	input  logic [4:0]          rS1,
	input  logic [4:0]          rS2,
	input  logic [4:0]          dest,
	input  logic [31:0]         imm32,
	input  logic [25:0]         jumpTarget,
	input  dlxCtrlPkg::aluOpT   aluOp,
	input  dlxCtrlPkg::memSizeT memSize,
	input  logic                aluSrcImm,
	input  logic                regWr,
	input  logic                memRd,
	input  logic                memWr,
	input  logic                memSigned,
	input  logic                loadHigh,
	input  logic                link,
	input  logic                branchEqz,
	input  logic                branchNez,
	input  logic                jump,
	input  logic                jumpReg,
	input  logic                illegal,
	input  dlxCtrlPkg::fwdSelT  fwdA,
	input  dlxCtrlPkg::fwdSelT  fwdB,
	output logic [4:0]          exRS1,
	output logic [4:0]          exRS2,
	output logic [4:0]          exDest,
	output logic [31:0]         exImm32,
	output logic [25:0]         exJumpTarget,
	output dlxCtrlPkg::aluOpT   exAluOp,
	output dlxCtrlPkg::memSizeT exMemSize,
	output logic                exAluSrcImm,
	output logic                exRegWr,
	output logic                exMemRd,
	output logic                exMemWr,
	output logic                exMemSigned,
	output logic                exLoadHigh,
	output logic                exLink,
	output logic                exBranchEqz,
	output logic                exBranchNez,
	output logic                exJump,
	output logic                exJumpReg,
	output logic                exIllegal,
	output dlxCtrlPkg::fwdSelT  exFwdA,
	output dlxCtrlPkg::fwdSelT  exFwdB
);

	logic bubble;

	assign bubble = !instrValid || stall;

	always_ff @(posedge clk)
	begin
		if (rst || bubble)	// reset state is a bubble too
		begin
			exRegWr <= 1'b0;
			exMemRd <= 1'b0;
			exMemWr <= 1'b0;
			exLink <= 1'b0;
			exBranchEqz <= 1'b0;
			exBranchNez <= 1'b0;
			exJump <= 1'b0;
			exJumpReg <= 1'b0;
			exIllegal <= 1'b0;
			exAluOp <= dlxCtrlPkg::ALU_PASSB;
			exFwdA <= dlxCtrlPkg::FWD_REGFILE;
			exFwdB <= dlxCtrlPkg::FWD_REGFILE;
		end
		else
		begin
			exRegWr <= regWr;
			exMemRd <= memRd;
			exMemWr <= memWr;
			exLink <= link;
			exBranchEqz <= branchEqz;
			exBranchNez <= branchNez;
			exJump <= jump;
			exJumpReg <= jumpReg;
			exIllegal <= illegal;
			exAluOp <= aluOp;
			exFwdA <= fwdA;
			exFwdB <= fwdB;
		end
	end

	// datapath fields, only meaningful alongside the controls
	always_ff @(posedge clk)
	begin
		exRS1 <= rS1;
		exRS2 <= rS2;
		exDest <= dest;
		exImm32 <= imm32;
		exJumpTarget <= jumpTarget;
		exMemSize <= memSize;
		exAluSrcImm <= aluSrcImm;
		exMemSigned <= memSigned;
		exLoadHigh <= loadHigh;
	end

endmodule

// ==== logic/dlxDecodeStage.sv ====
`timescale 1ns/1ps

module dlxDecodeStage
(
	input  logic                clk,
	input  logic                rst,
	input  logic [31:0]         instr,
	input  logic                instrValid,
	output logic                stall,
	output logic [4:0]          exRS1,
	output logic [4:0]          exRS2,
	output logic [4:0]          exDest,
	output logic [31:0]         exImm32,
	output logic [25:0]         exJumpTarget,
	output dlxCtrlPkg::aluOpT   exAluOp,
	output dlxCtrlPkg::memSizeT exMemSize,
	output logic                exAluSrcImm,
	output logic                exRegWr,
	output logic                exMemRd,
	output logic                exMemWr,
	output logic                exMemSigned,
	output logic                exLoadHigh,
	output logic                exLink,
	output logic                exBranchEqz,
	output logic                exBranchNez,
	output logic                exJump,
	output logic                exJumpReg,
	output logic                exIllegal,
	output dlxCtrlPkg::fwdSelT  exFwdA,
	output dlxCtrlPkg::fwdSelT  exFwdB
);

	logic [4:0]          rS1;
	logic [4:0]          rS2;
	logic [4:0]          dest;
	logic [31:0]         imm32;
	logic [25:0]         jumpTarget;
	dlxCtrlPkg::aluOpT   aluOp;
	dlxCtrlPkg::memSizeT memSize;
	logic                aluSrcImm;
	logic                usesRs1;
	logic                usesRs2;
	logic                regWr;
	logic                memRd;
	logic                memWr;
	logic                memSigned;
	logic                loadHigh;
	logic                link;
	logic                branchEqz;
	logic                branchNez;
	logic                jump;
	logic                jumpReg;
	logic                illegal;
	dlxCtrlPkg::fwdSelT  fwdA;
	dlxCtrlPkg::fwdSelT  fwdB;

	instrDecoder instrDecoder_inst
	(
		.instr(instr),
		.rS1(rS1),
		.rS2(rS2),
		.dest(dest),
		.imm32(imm32),
		.jumpTarget(jumpTarget),
		.aluOp(aluOp),
		.memSize(memSize),
		.aluSrcImm(aluSrcImm),
		.usesRs1(usesRs1),
		.usesRs2(usesRs2),
		.regWr(regWr),
		.memRd(memRd),
		.memWr(memWr),
		.memSigned(memSigned),
		.loadHigh(loadHigh),
		.link(link),
		.branchEqz(branchEqz),
		.branchNez(branchNez),
		.jump(jump),
		.jumpReg(jumpReg),
		.illegal(illegal)
	);

	hazardUnit hazardUnit_inst
	(
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.rS1(rS1),
		.rS2(rS2),
		.dest(dest),
		.usesRs1(usesRs1),
		.usesRs2(usesRs2),
		.regWr(regWr),
		.memRd(memRd),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stall(stall)
	);

	idExRegister idExRegister_inst
	(
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.stall(stall),
		.rS1(rS1),
		.rS2(rS2),
		.dest(dest),
		.imm32(imm32),
		.jumpTarget(jumpTarget),
		.aluOp(aluOp),
		.memSize(memSize),
		.aluSrcImm(aluSrcImm),
		.regWr(regWr),
		.memRd(memRd),
		.memWr(memWr),
		.memSigned(memSigned),
		.loadHigh(loadHigh),
		.link(link),
		.branchEqz(branchEqz),
		.branchNez(branchNez),
		.jump(jump),
		.jumpReg(jumpReg),
		.illegal(illegal),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.exRS1(exRS1),
		.exRS2(exRS2),
		.exDest(exDest),
		.exImm32(exImm32),
		.exJumpTarget(exJumpTarget),
		.exAluOp(exAluOp),
		.exMemSize(exMemSize),
		.exAluSrcImm(exAluSrcImm),
		.exRegWr(exRegWr),
		.exMemRd(exMemRd),
		.exMemWr(exMemWr),
		.exMemSigned(exMemSigned),
		.exLoadHigh(exLoadHigh),
		.exLink(exLink),
		.exBranchEqz(exBranchEqz),
		.exBranchNez(exBranchNez),
		.exJump(exJump),
		.exJumpReg(exJumpReg),
		.exIllegal(exIllegal),
		.exFwdA(exFwdA),
		.exFwdB(exFwdB)
	);

endmodule

// ==== verif/dlxDecodeTb.sv ====
`timescale 1ns/1ps

module dlxDecodeTb;

	localparam int COLS = 16;	// words per golden line
	localparam int MAX_VEC = 64;
	localparam int C_TAG = 0;
	localparam int C_INSTR = 1;
	localparam int C_VALID = 2;
	localparam int C_STALL = 3;
	localparam int C_REGWR = 4;
	localparam int C_MEMWR = 5;
	localparam int C_MEMRD = 6;
	localparam int C_DEST = 7;
	localparam int C_ALUOP = 8;
	localparam int C_FWDA = 9;
	localparam int C_FWDB = 10;
	localparam int C_IMM = 11;
	localparam int C_JUMP = 12;
	localparam int C_BEQZ = 13;
	localparam int C_BNEZ = 14;
	localparam int C_LINK = 15;

	logic                clk;
	logic                rst;
	logic [31:0]         instr;
	logic                instrValid;
	logic                stall;
	logic [4:0]          exRS1;
	logic [4:0]          exRS2;
	logic [4:0]          exDest;
	logic [31:0]         exImm32;
	logic [25:0]         exJumpTarget;
	dlxCtrlPkg::aluOpT   exAluOp;
	dlxCtrlPkg::memSizeT exMemSize;
	logic                exAluSrcImm;
	logic                exRegWr;
	logic                exMemRd;
	logic                exMemWr;
	logic                exMemSigned;
	logic                exLoadHigh;
	logic                exLink;
	logic                exBranchEqz;
	logic                exBranchNez;
	logic                exJump;
	logic                exJumpReg;
	logic                exIllegal;
	dlxCtrlPkg::fwdSelT  exFwdA;
	dlxCtrlPkg::fwdSelT  exFwdB;

	logic [31:0] golden [0:COLS*MAX_VEC-1];
	int          vecCount;
	int          errCount = 0;
	int          testCount = 0;
	int          failCount = 0;
	int          groupErrs = 0;
	int          cycleCount = 0;
	int          cycleLimit = MAX_VEC + 20;
	string       currentTest = "reset";

	dlxDecodeStage dlxDecodeStage_inst
	(
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.stall(stall),
		.exRS1(exRS1),
		.exRS2(exRS2),
		.exDest(exDest),
		.exImm32(exImm32),
		.exJumpTarget(exJumpTarget),
		.exAluOp(exAluOp),
		.exMemSize(exMemSize),
		.exAluSrcImm(exAluSrcImm),
		.exRegWr(exRegWr),
		.exMemRd(exMemRd),
		.exMemWr(exMemWr),
		.exMemSigned(exMemSigned),
		.exLoadHigh(exLoadHigh),
		.exLink(exLink),
		.exBranchEqz(exBranchEqz),
		.exBranchNez(exBranchNez),
		.exJump(exJump),
		.exJumpReg(exJumpReg),
		.exIllegal(exIllegal),
		.exFwdA(exFwdA),
		.exFwdB(exFwdB)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] field(input int vec, input int col);
		field = golden[vec*COLS+col];
	endfunction

	function automatic string groupName(input logic [31:0] tag);
		case (tag)
			32'd1: groupName = "alu_rtype";
			32'd2: groupName = "alu_itype";
			32'd3: groupName = "mem_lhi";
			32'd4: groupName = "jump_branch";
			32'd5: groupName = "nop_illegal";
			32'd6: groupName = "forwarding";
			32'd7: groupName = "load_use";
			32'd8: groupName = "invalid_bubble";
			default: groupName = "unknown";
		endcase
	endfunction

	task automatic checkValue(input int vec, input string fieldName,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s vector %0d %s expected %0h actual %0h",
				currentTest, vec, fieldName, expected, actual);
			errCount++;
			groupErrs++;
		end
	endtask

	// registered fields of vector v, one cycle after it was sampled
	task automatic checkExFields(input int v);
		checkValue(v, "exRegWr", field(v, C_REGWR), {31'd0, exRegWr});
		checkValue(v, "exMemWr", field(v, C_MEMWR), {31'd0, exMemWr});
		checkValue(v, "exMemRd", field(v, C_MEMRD), {31'd0, exMemRd});
		if (field(v, C_REGWR) != 32'd0)	// dest only matters with a write
			checkValue(v, "exDest", field(v, C_DEST), {27'd0, exDest});
		checkValue(v, "exAluOp", field(v, C_ALUOP), 32'(exAluOp));
		checkValue(v, "exFwdA", field(v, C_FWDA), 32'(exFwdA));
		checkValue(v, "exFwdB", field(v, C_FWDB), 32'(exFwdB));
		checkValue(v, "exImm32", field(v, C_IMM), exImm32);
		checkValue(v, "exJump", field(v, C_JUMP), {31'd0, exJump});
		checkValue(v, "exBranchEqz", field(v, C_BEQZ), {31'd0, exBranchEqz});
		checkValue(v, "exBranchNez", field(v, C_BNEZ), {31'd0, exBranchNez});
		checkValue(v, "exLink", field(v, C_LINK), {31'd0, exLink});
	endtask

	// fields the golden file does not carry, from the DLX encoding of the word
	task automatic checkDecodeFields(input int v);
		logic [31:0] word;
		logic [5:0]  opc;
		logic        live;
		logic        writes;
		logic        acts;
		logic        expIllegal;
		logic        expJumpReg;
		logic        expLoadHigh;
		logic        expSigned;
		logic        expSrcImm;
		logic [1:0]  expSize;
		word = field(v, C_INSTR);
		opc = word[31:26];
		live = (field(v, C_VALID) != 32'd0) && (field(v, C_STALL) == 32'd0);
		writes = (field(v, C_REGWR) != 32'd0) || (field(v, C_MEMWR) != 32'd0);
		acts = writes || (field(v, C_JUMP) != 32'd0) || (field(v, C_BEQZ) != 32'd0)
			|| (field(v, C_BNEZ) != 32'd0);
		expIllegal = live && !acts && (word != dlxIsaPkg::NOP_WORD);	// only nop and unknown do nothing
		expJumpReg = live && (opc == 6'h12 || opc == 6'h13);
		expLoadHigh = (opc == 6'h0f);
		expSigned = !opc[2];	// LBU and LHU have bit 2 set
		expSrcImm = (opc != 6'h00);
		expSize = (opc[1:0] == 2'b11) ? 2'd2 : opc[1:0];
		checkValue(v, "exRS1", {27'd0, word[25:21]}, {27'd0, exRS1});
		checkValue(v, "exRS2", {27'd0, word[20:16]}, {27'd0, exRS2});
		checkValue(v, "exJumpTarget", {6'd0, word[25:0]}, {6'd0, exJumpTarget});
		checkValue(v, "exLoadHigh", {31'd0, expLoadHigh}, {31'd0, exLoadHigh});
		checkValue(v, "exJumpReg", {31'd0, expJumpReg}, {31'd0, exJumpReg});
		checkValue(v, "exIllegal", {31'd0, expIllegal}, {31'd0, exIllegal});
		if (field(v, C_MEMRD) != 32'd0 || field(v, C_MEMWR) != 32'd0)
			checkValue(v, "exMemSize", {30'd0, expSize}, 32'(exMemSize));
		if (field(v, C_MEMRD) != 32'd0)
			checkValue(v, "exMemSigned", {31'd0, expSigned}, {31'd0, exMemSigned});
		if (writes && field(v, C_JUMP) == 32'd0)
			checkValue(v, "exAluSrcImm", {31'd0, expSrcImm}, {31'd0, exAluSrcImm});
	endtask

	task automatic reportTest();
		testCount++;
		if (groupErrs == 0)
			$display("test %s: passed", currentTest);
		else
		begin
			$display("test %s: failed with %0d errors", currentTest, groupErrs);
			failCount++;
		end
		groupErrs = 0;
	endtask

	initial
	begin
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles", cycleLimit);
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		int v;
		for (int i = 0; i < COLS*MAX_VEC; i++)
			golden[i] = {16'hdead, i[15:0]};	// never a valid tag
		$readmemh("verif/decode_golden.mem", golden);
		vecCount = 0;
		while (vecCount < MAX_VEC && golden[vecCount*COLS] < 32'd16)
			vecCount++;
		cycleLimit = vecCount + 20;

		rst = 1'b1;
		instr = 32'h2001_0005;	// valid ADDI to r1 held through reset
		instrValid = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// nothing issued yet
		checkValue(-1, "exRegWr", 32'd0, {31'd0, exRegWr});
		checkValue(-1, "exMemWr", 32'd0, {31'd0, exMemWr});
		checkValue(-1, "exMemRd", 32'd0, {31'd0, exMemRd});
		checkValue(-1, "exJump", 32'd0, {31'd0, exJump});
		checkValue(-1, "exBranchEqz", 32'd0, {31'd0, exBranchEqz});
		checkValue(-1, "exBranchNez", 32'd0, {31'd0, exBranchNez});
		checkValue(-1, "exLink", 32'd0, {31'd0, exLink});
		reportTest();
		if (vecCount == 0)
		begin
			$display("no vectors could be read from the golden file");
			errCount++;
		end

		for (v = 0; v < vecCount; v++)
		begin
			currentTest = groupName(field(v, C_TAG));
			instr = field(v, C_INSTR);
			instrValid = (field(v, C_VALID) != 32'd0);
			#5;
			checkValue(v, "stall", field(v, C_STALL), {31'd0, stall});
			@(negedge clk);
			checkExFields(v);
			checkDecodeFields(v);
			if (v == vecCount - 1 || field(v + 1, C_TAG) != field(v, C_TAG))
				reportTest();
		end

		$display("tests %0d, failed %0d, mismatches %0d", testCount, failCount, errCount);
		if (errCount == 0 && failCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== verif/decode_golden.mem ====
// tag instr valid stall | expected ex: regWr memWr memRd dest aluOp fwdA fwdB imm32
// jump branchEqz branchNez link (all hex, one vector per line)
1 00225020 1 0 1 0 0 0a 0 0 0 00005020 0 0 0 0
1 00225822 1 0 1 0 0 0b 1 0 0 00005822 0 0 0 0
1 00226024 1 0 1 0 0 0c 2 0 0 00006024 0 0 0 0
1 00226825 1 0 1 0 0 0d 3 0 0 00006825 0 0 0 0
1 00227026 1 0 1 0 0 0e 4 0 0 00007026 0 0 0 0
1 00227804 1 0 1 0 0 0f 5 0 0 00007804 0 0 0 0
1 0022802a 1 0 1 0 0 10 a 0 0 ffff802a 0 0 0 0
1 0022882d 1 0 1 0 0 11 d 0 0 ffff882d 0 0 0 0
1 00229007 1 0 1 0 0 12 7 0 0 ffff9007 0 0 0 0
2 2034fff0 1 0 1 0 0 14 0 0 0 fffffff0 0 0 0 0
2 30358001 1 0 1 0 0 15 2 0 0 00008001 0 0 0 0
2 3456ff00 1 0 1 0 0 16 3 0 0 0000ff00 0 0 0 0
2 38578000 1 0 1 0 0 17 4 0 0 00008000 0 0 0 0
2 28380004 1 0 1 0 0 18 1 0 0 00000004 0 0 0 0
2 68598000 1 0 1 0 0 19 a 0 0 ffff8000 0 0 0 0
2 5c3a0003 1 0 1 0 0 1a 7 0 0 00000003 0 0 0 0
3 8c650010 1 0 1 0 1 05 0 0 0 00000010 0 0 0 0
3 90668004 1 0 1 0 1 06 0 0 0 00008004 0 0 0 0
3 8467fffe 1 0 1 0 1 07 0 0 0 fffffffe 0 0 0 0
3 ac640008 1 0 0 1 0 00 0 0 0 00000008 0 0 0 0
3 a064ffff 1 0 0 1 0 00 0 0 0 ffffffff 0 0 0 0
3 3c081234 1 0 1 0 0 08 e 0 0 00001234 0 0 0 0
4 08000100 1 0 0 0 0 00 e 0 0 00000100 1 0 0 0
4 0c008000 1 0 1 0 0 1f e 0 0 ffff8000 1 0 0 1
4 48600000 1 0 0 0 0 00 e 0 0 00000000 1 0 0 0
4 4c800000 1 0 1 0 0 1f e 0 0 00000000 1 0 0 1
4 10200040 1 0 0 0 0 00 e 0 0 00000040 0 1 0 0
4 1440ffc0 1 0 0 0 0 00 e 0 0 ffffffc0 0 0 1 0
5 00000015 1 0 0 0 0 00 e 0 0 00000015 0 0 0 0
5 fc001234 1 0 0 0 0 00 e 0 0 00001234 0 0 0 0
5 0022503f 1 0 0 0 0 00 e 0 0 0000503f 0 0 0 0
6 00224820 1 0 1 0 0 09 0 0 0 00004820 0 0 0 0
6 01215022 1 0 1 0 0 0a 1 1 0 00005022 0 0 0 0
6 00495824 1 0 1 0 0 0b 2 0 2 00005824 0 0 0 0
6 014b6025 1 0 1 0 0 0c 3 2 1 00006025 0 0 0 0
6 20200001 1 0 1 0 0 00 0 0 0 00000001 0 0 0 0
6 00006820 1 0 1 0 0 0d 0 0 0 00006820 0 0 0 0
7 8c6e0000 1 0 1 0 1 0e 0 0 0 00000000 0 0 0 0
7 01c17820 1 1 0 0 0 00 e 0 0 00007820 0 0 0 0
7 01c17820 1 0 1 0 0 0f 0 2 0 00007820 0 0 0 0
7 8c700004 1 0 1 0 1 10 0 0 0 00000004 0 0 0 0
7 ac700000 1 1 0 0 0 00 e 0 0 00000000 0 0 0 0
7 ac700000 1 0 0 1 0 00 0 0 2 00000000 0 0 0 0
8 00228820 0 0 0 0 0 00 e 0 0 ffff8820 0 0 0 0
8 02219020 1 0 1 0 0 12 0 0 0 ffff9020 0 0 0 0
8 02519822 1 0 1 0 0 13 1 1 0 ffff9822 0 0 0 0

// ==== sources.f ====
logic/dlxIsaPkg.sv
logic/dlxCtrlPkg.sv
logic/instrDecoder.sv
logic/hazardUnit.sv
logic/idExRegister.sv
logic/dlxDecodeStage.sv
verif/dlxDecodeTb.sv

// ==== Makefile ====
TOP = dlxDecodeTb
LOG = sim.log

all: run

build:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
